/* rv_exec_core.f */
+incdir+hw
hw/rv_isa_pkg.sv
hw/rv_core_pkg.sv
hw/rv_ctrl_if.sv
hw/rv_inst_queue.sv
hw/rv_control_unit.sv
hw/rv_regfile.sv
hw/rv_alu.sv
hw/rv_exec_core.sv
bench/rv_exec_core_tb.sv

/* Makefile */
# Verilator build and run for the rv_exec_core testbench

VERILATOR ?= verilator
TOP       ?= rv_exec_core_tb
FILELIST  ?= rv_exec_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= Test failures found

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/rv_exec_core_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rv_core_cfg.svh"

module rv_exec_core_tb;

    localparam int NUM_INSTS   = 2000;
    localparam int CYCLE_LIMIT = NUM_INSTS * 8;
    // add sub sll slt sltu xor srl sra or and, entry 0 in the low bits
    localparam logic [29:0] R_F3  = {3'd7, 3'd6, 3'd5, 3'd5, 3'd4, 3'd3, 3'd2, 3'd1, 3'd0, 3'd0};
    localparam logic [9:0]  R_ALT = 10'b0010000010;
    localparam logic [17:0] B_F3  = {3'd7, 3'd6, 3'd5, 3'd4, 3'd1, 3'd0};

    logic             clk;
    logic             rst_n;
    logic             in_valid;
    logic [`XLEN-1:0] in_pc;
    logic [31:0]      in_inst;
    logic             credit_return;
    logic             retire_valid;
    logic             retire_ready;
    logic [`XLEN-1:0] retire_pc;
    logic [4:0]       retire_rd;
    logic             retire_we;
    logic [`XLEN-1:0] retire_wdata;
    logic [`XLEN-1:0] retire_next_pc;
    logic             retire_illegal;

    logic [31:0]      rng_state;
    logic [`XLEN-1:0] model_regs [32];
    logic [`XLEN-1:0] pc_fifo [$];
    logic [31:0]      inst_fifo [$];
    int               credits;
    int               sent;
    int               retired;
    int               cycles;
    int               value_errors;
    int               other_errors;
    logic             was_stalled;
    logic [`XLEN-1:0] held_pc, held_wdata, held_next_pc;
    logic [4:0]       held_rd;
    logic             held_we, held_illegal;

    rv_exec_core dut0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .in_valid       (in_valid),
        .in_pc          (in_pc),
        .in_inst        (in_inst),
        .credit_return  (credit_return),
        .retire_valid   (retire_valid),
        .retire_ready   (retire_ready),
        .retire_pc      (retire_pc),
        .retire_rd      (retire_rd),
        .retire_we      (retire_we),
        .retire_wdata   (retire_wdata),
        .retire_next_pc (retire_next_pc),
        .retire_illegal (retire_illegal)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function logic [31:0] rand32();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function logic [31:0] make_inst();
        logic [31:0] r, v, w;
        logic [4:0]  rd, rs1, rs2;
        int          k;
        r   = rand32();
        v   = rand32();
        rd  = {1'b0, r[3:0]};   // x0..x15, more reuse
        rs1 = {1'b0, r[7:4]};
        rs2 = {1'b0, r[11:8]};
        k   = r[20:16] % 22;
        if (r[31:24] < 8'd26) begin
            case (r[13:12])
                2'd0:    w = {v[31:7], 7'b0000011};   // load
                2'd1:    w = {v[31:7], 7'b0100011};   // store
                default: w = v;
            endcase
        end else if (k == 0) begin
            w = {v[31:20], rs1, 3'b000, rd, 7'b0010011};
        end else if (k == 1) begin
            w = {v[31:12], rd, 7'b0110111};
        end else if (k == 2) begin
            w = {v[31:12], rd, 7'b0010111};
        end else if (k == 3) begin
            w = {v[31:12], rd, 7'b1101111};
        end else if (k == 4) begin
            w = {v[31:20], rs1, 3'b000, rd, 7'b1100111};
        end else if (k < 15) begin
            w = {1'b0, R_ALT[k-5], 5'b0, rs2, rs1, R_F3[(k-5)*3 +: 3], rd, 7'b0110011};
        end else if (k == 15) begin
            w = {7'b0, rs2, rs1, 3'b000, rd, 7'b0111011};   // addw
        end else begin
            w = {v[31:25], rs2, rs1, B_F3[(k-16)*3 +: 3], v[11:7], 7'b1100011};
        end
        return w;
    endfunction

    // reference behavior of one instruction against the model registers
    task automatic predict(input logic [`XLEN-1:0] pc, input logic [31:0] inst,
                           output logic we, output logic [`XLEN-1:0] wdata,
                           output logic [`XLEN-1:0] npc, output logic bad);
        logic [`XLEN-1:0] a, b, imm_i, imm_u, imm_b, imm_j, link;
        logic [31:0]      word;
        logic [2:0]       f3;
        logic [6:0]       f7;
        logic             taken;
        a     = model_regs[inst[19:15]];
        b     = model_regs[inst[24:20]];
        f3    = inst[14:12];
        f7    = inst[31:25];
        imm_i = {{(`XLEN-12){inst[31]}}, inst[31:20]};
        imm_u = {{(`XLEN-32){inst[31]}}, inst[31:12], 12'h000};
        imm_b = {{(`XLEN-13){inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
        imm_j = {{(`XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
        link  = pc + `XLEN'(4);
        word  = a[31:0] + b[31:0];
        we    = 1'b1;
        wdata = '0;
        npc   = link;
        bad   = 1'b0;
        taken = 1'b0;
        case (inst[6:0])
            7'b0010011: begin
                if (f3 == 3'b000)
                    wdata = a + imm_i;
                else
                    bad = 1'b1;   // shifts and logic immediates not supported
            end
            7'b0110111: wdata = imm_u;
            7'b0010111: wdata = pc + imm_u;
            7'b1101111: begin
                wdata = link;
                npc   = pc + imm_j;
            end
            7'b1100111: begin
                wdata = link;
                npc   = (a + imm_i) & ~`XLEN'(1);
                bad   = (f3 != 3'b000);
            end
            7'b0110011: begin
                if (f7 == 7'b0000000) begin
                    case (f3)
                        3'b000:  wdata = a + b;
                        3'b001:  wdata = a << b[5:0];
                        3'b010:  wdata = `XLEN'($signed(a) < $signed(b));
                        3'b011:  wdata = `XLEN'(a < b);
                        3'b100:  wdata = a ^ b;
                        3'b101:  wdata = a >> b[5:0];
                        3'b110:  wdata = a | b;
                        default: wdata = a & b;
                    endcase
                end else if (f7 == 7'b0100000 && f3 == 3'b000) begin
                    wdata = a - b;
                end else if (f7 == 7'b0100000 && f3 == 3'b101) begin
                    wdata = $signed(a) >>> b[5:0];
                end else begin
                    bad = 1'b1;
                end
            end
            7'b0111011: begin
                wdata = {{(`XLEN-32){word[31]}}, word};
                bad   = (f3 != 3'b000) || (f7 != 7'b0000000);
            end
            7'b1100011: begin
                we = 1'b0;
                case (f3)
                    3'b000:  taken = (a == b);
                    3'b001:  taken = (a != b);
                    3'b100:  taken = ($signed(a) < $signed(b));
                    3'b101:  taken = ($signed(a) >= $signed(b));
                    3'b110:  taken = (a < b);
                    3'b111:  taken = (a >= b);
                    default: bad = 1'b1;
                endcase
                if (taken)
                    npc = pc + imm_b;
            end
            default: bad = 1'b1;
        endcase
        if (bad) begin
            we  = 1'b0;
            npc = link;
        end
    endtask

    task automatic expect_equal(input string name, input logic [`XLEN-1:0] got,
                                input logic [`XLEN-1:0] exp);
        assert (got === exp) else begin
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
            value_errors++;
        end
    endtask

    task automatic take_retire();
        logic [`XLEN-1:0] pc, wdata, npc;
        logic [31:0]      inst;
        logic             we, bad;
        assert (pc_fifo.size() != 0) else begin
            $display("retire record arrived with no instruction outstanding");
            other_errors++;
        end
        if (pc_fifo.size() != 0) begin
            pc   = pc_fifo.pop_front();
            inst = inst_fifo.pop_front();
            predict(pc, inst, we, wdata, npc, bad);
            expect_equal("retire_pc", retire_pc, pc);
            expect_equal("retire_rd", `XLEN'(retire_rd), `XLEN'(inst[11:7]));
            expect_equal("retire_we", `XLEN'(retire_we), `XLEN'(we));
            expect_equal("retire_next_pc", retire_next_pc, npc);
            expect_equal("retire_illegal", `XLEN'(retire_illegal), `XLEN'(bad));
            if (we)
                expect_equal("retire_wdata", retire_wdata, wdata);
            if (we && inst[11:7] != 5'd0)
                model_regs[inst[11:7]] = wdata;   // x0 never written
            retired++;
        end
    endtask

    task automatic check_hold();
        if (was_stalled) begin
            expect_equal("retire_valid", `XLEN'(retire_valid), `XLEN'(1));
            expect_equal("retire_pc", retire_pc, held_pc);
            expect_equal("retire_rd", `XLEN'(retire_rd), `XLEN'(held_rd));
            expect_equal("retire_we", `XLEN'(retire_we), `XLEN'(held_we));
            expect_equal("retire_wdata", retire_wdata, held_wdata);
            expect_equal("retire_next_pc", retire_next_pc, held_next_pc);
            expect_equal("retire_illegal", `XLEN'(retire_illegal), `XLEN'(held_illegal));
        end
        was_stalled  = retire_valid && !retire_ready;
        held_pc      = retire_pc;
        held_rd      = retire_rd;
        held_we      = retire_we;
        held_wdata   = retire_wdata;
        held_next_pc = retire_next_pc;
        held_illegal = retire_illegal;
    endtask

    task automatic drive_inputs();
        logic [31:0]      r, hi, lo, inst;
        logic [`XLEN-1:0] pc;
        r = rand32();
        if (sent < NUM_INSTS && credits > 0 && r[1:0] != 2'b00) begin
            hi   = rand32();
            lo   = rand32();
            pc   = {hi, lo[31:2], 2'b00};
            inst = make_inst();
            in_valid <= 1'b1;
            in_pc    <= pc;
            in_inst  <= inst;
            pc_fifo.push_back(pc);
            inst_fifo.push_back(inst);
            credits--;
            sent++;
        end else begin
            in_valid <= 1'b0;
        end
        retire_ready <= (r[15:8] >= 8'd77);   // low ~30% of cycles
    endtask

    initial begin
        rng_state    = 32'h739c_6a24;
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        in_pc        = '0;
        in_inst      = '0;
        retire_ready = 1'b0;
        credits      = `QUEUE_DEPTH;
        sent         = 0;
        retired      = 0;
        cycles       = 0;
        value_errors = 0;
        other_errors = 0;
        was_stalled  = 1'b0;
        for (int i = 0; i < 32; i++)
            model_regs[i] = '0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        assert (!retire_valid && !credit_return) else begin
            $display("retire_valid or credit_return high in the cycle after reset");
            other_errors++;
        end
        while (retired < NUM_INSTS && cycles < CYCLE_LIMIT) begin
            if (credit_return)
                credits++;
            assert (credits <= `QUEUE_DEPTH) else begin
                $display("credit count %0d went above the queue depth", credits);
                other_errors++;
            end
            if (retire_valid && retire_ready)
                take_retire();
            check_hold();
            drive_inputs();
            @(posedge clk);
            cycles++;
        end
        if (retired < NUM_INSTS) begin
            $display("timeout after %0d cycles with %0d of %0d instructions retired",
                     cycles, retired, NUM_INSTS);
            other_errors++;
        end else begin
            assert (credits == `QUEUE_DEPTH) else begin
                $display("%0d credits held at the end instead of all returned", credits);
                other_errors++;
            end
            retire_ready <= 1'b1;
            repeat (4) begin
                assert (!retire_valid && !credit_return) else begin
                    $display("extra retire record or credit after the last instruction");
                    other_errors++;
                end
                @(posedge clk);
            end
        end
        $display("value errors: %0d, other errors: %0d, retired: %0d",
                 value_errors, other_errors, retired);
        if (value_errors == 0 && other_errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

/* hw/rv_exec_core.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rv_core_cfg.svh"

module rv_exec_core (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    input  logic [`XLEN-1:0] in_pc,
    input  logic [31:0]      in_inst,
    output logic             credit_return,
    output logic             retire_valid,
    input  logic             retire_ready,
    output logic [`XLEN-1:0] retire_pc,
    output logic [4:0]       retire_rd,
    output logic             retire_we,
    output logic [`XLEN-1:0] retire_wdata,
    output logic [`XLEN-1:0] retire_next_pc,
    output logic             retire_illegal
);

    rv_core_pkg::queue_entry_t push_entry;
    rv_core_pkg::queue_entry_t head;
    logic                      head_valid;
    logic                      pop;
    logic                      rf_we;
    logic [`XLEN-1:0]          alu_result;
    logic [`XLEN-1:0]          next_pc;

    rv_ctrl_if ctrl_bus ();

    assign push_entry = '{pc: in_pc, inst: in_inst};

    rv_inst_queue u_queue (
        .clk           (clk),
        .rst_n         (rst_n),
        .push          (in_valid),
        .push_entry    (push_entry),
        .pop           (pop),
        .head_valid    (head_valid),
        .head          (head),
        .credit_return (credit_return)
    );

    assign ctrl_bus.pc   = head.pc;
    assign ctrl_bus.inst = head.inst;

    rv_control_unit u_ctrl (
        .inst (head.inst),
        .ctrl (ctrl_bus.ctrl)
    );

    // write lands on the same edge that loads the retire register
    assign pop   = head_valid && (!retire_valid || retire_ready);
    assign rf_we = pop && ctrl_bus.ctrl.rf_we;

    rv_regfile u_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_addr (head.inst[19:15]),
        .rs2_addr (head.inst[24:20]),
        .rd_addr  (head.inst[11:7]),
        .we       (rf_we),
        .wdata    (alu_result),
        .rs1_data (ctrl_bus.rs1_data),
        .rs2_data (ctrl_bus.rs2_data)
    );

    rv_alu u_alu (
        .ctrl_port (ctrl_bus.exec),
        .result    (alu_result),
        .next_pc   (next_pc)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            retire_valid <= 1'b0;
        else if (pop)
            retire_valid <= 1'b1;
        else if (retire_ready)
            retire_valid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            retire_pc      <= head.pc;
            retire_rd      <= head.inst[11:7];
            retire_we      <= ctrl_bus.ctrl.rf_we;
            retire_wdata   <= alu_result;
            retire_next_pc <= next_pc;
            retire_illegal <= ctrl_bus.ctrl.illegal;
        end
    end

    // stalled record must not change until taken
    assert property (@(posedge clk) disable iff (!rst_n)
        (retire_valid && !retire_ready) |=>
            (retire_valid && $stable(retire_pc) && $stable(retire_rd)
             && $stable(retire_we) && $stable(retire_wdata)
             && $stable(retire_next_pc) && $stable(retire_illegal)));

endmodule

`default_nettype wire

/* hw/rv_alu.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rv_core_cfg.svh"

module rv_alu (
    rv_ctrl_if.exec          ctrl_port,
    output logic [`XLEN-1:0] result,
    output logic [`XLEN-1:0] next_pc
);

    localparam int SH_W = $clog2(`XLEN);

    logic [31:0]      inst;
    logic [`XLEN-1:0] pc, rs1, rs2;
    logic [`XLEN-1:0] imm_i, imm_u, imm_b, imm_j;
    logic [`XLEN-1:0] op_a, op_b, raw, pc_plus4, br_target, jalr_sum;
    logic [SH_W-1:0]  shamt;
    logic             eq, lt;

    assign inst = ctrl_port.inst;
    assign pc   = ctrl_port.pc;
    assign rs1  = ctrl_port.rs1_data;
    assign rs2  = ctrl_port.rs2_data;

    assign imm_i = {{(`XLEN-12){inst[31]}}, inst[31:20]};
    assign imm_u = {{(`XLEN-32){inst[31]}}, inst[31:12], 12'b0};
    assign imm_b = {{(`XLEN-13){inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_j = {{(`XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    assign op_a = (ctrl_port.ctrl.src1_sel == rv_core_pkg::PC) ? pc : rs1;

    always_comb begin
        unique case (ctrl_port.ctrl.src2_sel)
            rv_core_pkg::IMM_I: op_b = imm_i;
            rv_core_pkg::IMM_U: op_b = imm_u;
            rv_core_pkg::FOUR:  op_b = `XLEN'(4);
            default:            op_b = rs2;
        endcase
    end

    assign shamt = op_b[SH_W-1:0];   // rv64 uses 6 shift bits

    always_comb begin
        unique case (ctrl_port.ctrl.alu_op)
            rv_isa_pkg::SUB:    raw = op_a - op_b;
            rv_isa_pkg::SLT:    raw = `XLEN'($signed(op_a) < $signed(op_b));
            rv_isa_pkg::SLTU:   raw = `XLEN'(op_a < op_b);
            rv_isa_pkg::AND:    raw = op_a & op_b;
            rv_isa_pkg::OR:     raw = op_a | op_b;
            rv_isa_pkg::XOR:    raw = op_a ^ op_b;
            rv_isa_pkg::SLL:    raw = op_a << shamt;
            rv_isa_pkg::SRL:    raw = op_a >> shamt;
            rv_isa_pkg::SRA:    raw = $signed(op_a) >>> shamt;
            rv_isa_pkg::PASS_B: raw = op_b;
            default:            raw = op_a + op_b;
        endcase
    end

    // addw keeps the low word, sign extended
    assign result = ctrl_port.ctrl.word_op ? {{(`XLEN-32){raw[31]}}, raw[31:0]} : raw;

    assign eq = (rs1 == rs2);
    assign lt = ctrl_port.ctrl.cmp_unsigned ? (rs1 < rs2) : ($signed(rs1) < $signed(rs2));

    assign pc_plus4  = pc + `XLEN'(4);
    assign br_target = pc + imm_b;
    assign jalr_sum  = rs1 + imm_i;

    always_comb begin
        unique case (ctrl_port.ctrl.nextpc_sel)
            rv_core_pkg::JAL:  next_pc = pc + imm_j;
            rv_core_pkg::JALR: next_pc = {jalr_sum[`XLEN-1:1], 1'b0};
            rv_core_pkg::BEQ:  next_pc = eq ? br_target : pc_plus4;
            rv_core_pkg::BNE:  next_pc = eq ? pc_plus4 : br_target;
            rv_core_pkg::BLT:  next_pc = lt ? br_target : pc_plus4;
            rv_core_pkg::BGE:  next_pc = lt ? pc_plus4 : br_target;
            default:           next_pc = pc_plus4;
        endcase
    end

endmodule

`default_nettype wire

/* hw/rv_regfile.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rv_core_cfg.svh"

module rv_regfile (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [4:0]       rs1_addr,
    input  logic [4:0]       rs2_addr,
    input  logic [4:0]       rd_addr,
    input  logic             we,
    input  logic [`XLEN-1:0] wdata,
    output logic [`XLEN-1:0] rs1_data,
    output logic [`XLEN-1:0] rs2_data
);

    logic [`XLEN-1:0] regs [`NUM_REGS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `NUM_REGS; i++)
                regs[i] <= '0;
        end else if (we && rd_addr != 5'd0) begin   // x0 stays zero
            regs[rd_addr] <= wdata;
        end
    end

    // combinational reads, same-edge write is seen next cycle
    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

endmodule

`default_nettype wire

/* hw/rv_control_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_control_unit (
    input  logic [31:0]        inst,
    output rv_core_pkg::ctrl_t ctrl
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    logic inst_addi, inst_lui, inst_auipc, inst_jal, inst_jalr;
    logic inst_add, inst_sub, inst_sll, inst_slt, inst_sltu;
    logic inst_xor, inst_srl, inst_sra, inst_or, inst_and;
    logic inst_addw;
    logic inst_beq, inst_bne, inst_blt, inst_bge, inst_bltu, inst_bgeu;
    logic op_rr, op_br, legal;

    logic is_op;
    assign is_op = (opcode == rv_isa_pkg::OP);

    assign inst_addi  = (opcode == rv_isa_pkg::OP_IMM) && (funct3 == rv_isa_pkg::F3_ADD_SUB);
    assign inst_lui   = (opcode == rv_isa_pkg::LUI);
    assign inst_auipc = (opcode == rv_isa_pkg::AUIPC);
    assign inst_jal   = (opcode == rv_isa_pkg::JAL);
    assign inst_jalr  = (opcode == rv_isa_pkg::JALR) && (funct3 == 3'b000);

    assign inst_add  = is_op && funct3 == rv_isa_pkg::F3_ADD_SUB && funct7 == rv_isa_pkg::F7_BASE;
    assign inst_sub  = is_op && funct3 == rv_isa_pkg::F3_ADD_SUB && funct7 == rv_isa_pkg::F7_ALT;
    assign inst_sll  = is_op && funct3 == rv_isa_pkg::F3_SLL && funct7 == rv_isa_pkg::F7_BASE;
    assign inst_slt  = is_op && funct3 == rv_isa_pkg::F3_SLT && funct7 == rv_isa_pkg::F7_BASE;
    assign inst_sltu = is_op && funct3 == rv_isa_pkg::F3_SLTU && funct7 == rv_isa_pkg::F7_BASE;
    assign inst_xor  = is_op && funct3 == rv_isa_pkg::F3_XOR && funct7 == rv_isa_pkg::F7_BASE;
    assign inst_srl  = is_op && funct3 == rv_isa_pkg::F3_SRL_SRA && funct7 == rv_isa_pkg::F7_BASE;
    assign inst_sra  = is_op && funct3 == rv_isa_pkg::F3_SRL_SRA && funct7 == rv_isa_pkg::F7_ALT;
    assign inst_or   = is_op && funct3 == rv_isa_pkg::F3_OR && funct7 == rv_isa_pkg::F7_BASE;
    assign inst_and  = is_op && funct3 == rv_isa_pkg::F3_AND && funct7 == rv_isa_pkg::F7_BASE;

    assign inst_addw = (opcode == rv_isa_pkg::OP_32) && (funct3 == rv_isa_pkg::F3_ADD_SUB)
                       && (funct7 == rv_isa_pkg::F7_BASE);

    assign inst_beq  = (opcode == rv_isa_pkg::BRANCH) && (funct3 == rv_isa_pkg::F3_BEQ);
    assign inst_bne  = (opcode == rv_isa_pkg::BRANCH) && (funct3 == rv_isa_pkg::F3_BNE);
    assign inst_blt  = (opcode == rv_isa_pkg::BRANCH) && (funct3 == rv_isa_pkg::F3_BLT);
    assign inst_bge  = (opcode == rv_isa_pkg::BRANCH) && (funct3 == rv_isa_pkg::F3_BGE);
    assign inst_bltu = (opcode == rv_isa_pkg::BRANCH) && (funct3 == rv_isa_pkg::F3_BLTU);
    assign inst_bgeu = (opcode == rv_isa_pkg::BRANCH) && (funct3 == rv_isa_pkg::F3_BGEU);

    assign op_rr = inst_add | inst_sub | inst_sll | inst_slt | inst_sltu | inst_xor
                 | inst_srl | inst_sra | inst_or | inst_and | inst_addw;
    assign op_br = inst_beq | inst_bne | inst_blt | inst_bge | inst_bltu | inst_bgeu;

    // loads, stores and anything unmatched end up here as illegal
    assign legal = inst_addi | inst_lui | inst_auipc | inst_jal | inst_jalr | op_rr | op_br;

    always_comb begin
        ctrl.alu_op = rv_isa_pkg::ADD;
        if (inst_sub)
            ctrl.alu_op = rv_isa_pkg::SUB;
        else if (inst_slt)
            ctrl.alu_op = rv_isa_pkg::SLT;
        else if (inst_sltu)
            ctrl.alu_op = rv_isa_pkg::SLTU;
        else if (inst_and)
            ctrl.alu_op = rv_isa_pkg::AND;
        else if (inst_or)
            ctrl.alu_op = rv_isa_pkg::OR;
        else if (inst_xor)
            ctrl.alu_op = rv_isa_pkg::XOR;
        else if (inst_sll)
            ctrl.alu_op = rv_isa_pkg::SLL;
        else if (inst_srl)
            ctrl.alu_op = rv_isa_pkg::SRL;
        else if (inst_sra)
            ctrl.alu_op = rv_isa_pkg::SRA;
        else if (inst_lui)
            ctrl.alu_op = rv_isa_pkg::PASS_B;

        ctrl.src1_sel = (inst_auipc | inst_jal | inst_jalr) ? rv_core_pkg::PC : rv_core_pkg::RS1;

        ctrl.src2_sel = rv_core_pkg::RS2;
        if (inst_addi)
            ctrl.src2_sel = rv_core_pkg::IMM_I;
        else if (inst_lui | inst_auipc)
            ctrl.src2_sel = rv_core_pkg::IMM_U;
        else if (inst_jal | inst_jalr)
            ctrl.src2_sel = rv_core_pkg::FOUR;   // link value

        ctrl.nextpc_sel = rv_core_pkg::SEQ;
        if (inst_jal)
            ctrl.nextpc_sel = rv_core_pkg::JAL;
        else if (inst_jalr)
            ctrl.nextpc_sel = rv_core_pkg::JALR;
        else if (inst_beq)
            ctrl.nextpc_sel = rv_core_pkg::BEQ;
        else if (inst_bne)
            ctrl.nextpc_sel = rv_core_pkg::BNE;
        else if (inst_blt | inst_bltu)
            ctrl.nextpc_sel = rv_core_pkg::BLT;
        else if (inst_bge | inst_bgeu)
            ctrl.nextpc_sel = rv_core_pkg::BGE;

        ctrl.cmp_unsigned = inst_bltu | inst_bgeu;
        ctrl.word_op      = inst_addw;
        ctrl.rf_we        = legal & ~op_br;   // everything legal but branches writes rd
        ctrl.illegal      = ~legal;
    end

endmodule

`default_nettype wire

/* hw/rv_inst_queue.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rv_core_cfg.svh"

module rv_inst_queue (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       push,
    input  rv_core_pkg::queue_entry_t  push_entry,
    input  logic                       pop,
    output logic                       head_valid,
    output rv_core_pkg::queue_entry_t  head,
    output logic                       credit_return
);

    localparam int PTR_W = $clog2(`QUEUE_DEPTH);
    localparam int CNT_W = $clog2(`QUEUE_DEPTH + 1);

    rv_core_pkg::queue_entry_t storage [`QUEUE_DEPTH];
    logic [PTR_W-1:0]          wr_ptr;
    logic [PTR_W-1:0]          rd_ptr;
    logic [CNT_W-1:0]          count;

    function automatic logic [PTR_W-1:0] bump(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(`QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            credit_return <= 1'b0;
        end else begin
            if (push)
                wr_ptr <= bump(wr_ptr);
            if (pop)
                rd_ptr <= bump(rd_ptr);
            count         <= count + CNT_W'(push) - CNT_W'(pop);
            credit_return <= pop;   // one credit back per pop
        end
    end

    always_ff @(posedge clk) begin
        if (push)
            storage[wr_ptr] <= push_entry;
    end

    assign head_valid = (count != '0);
    assign head       = storage[rd_ptr];

    // upstream must hold a credit to push
    assert property (@(posedge clk) disable iff (!rst_n)
        push |-> (count != CNT_W'(`QUEUE_DEPTH)));

    assert property (@(posedge clk) disable iff (!rst_n)
        pop |-> head_valid);

endmodule

`default_nettype wire

/* hw/rv_ctrl_if.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rv_core_cfg.svh"

interface rv_ctrl_if;

    rv_core_pkg::ctrl_t ctrl;
    logic [`XLEN-1:0]   pc;
    logic [31:0]        inst;
    logic [`XLEN-1:0]   rs1_data;
    logic [`XLEN-1:0]   rs2_data;

    modport decode (
        output ctrl, pc, inst, rs1_data, rs2_data
    );

    modport exec (
        input ctrl, pc, inst, rs1_data, rs2_data
    );

endinterface

`default_nettype wire

/* hw/rv_core_pkg.sv */
`default_nettype none

`include "rv_core_cfg.svh"

package rv_core_pkg;

    typedef enum logic {
        RS1,
        PC
    } src1_sel_e;

    typedef enum logic [1:0] {
        RS2,
        IMM_I,
        IMM_U,
        FOUR
    } src2_sel_e;

    // bltu/bgeu reuse BLT/BGE with cmp_unsigned
    typedef enum logic [2:0] {
        SEQ, JAL, JALR, BEQ, BNE, BLT, BGE
    } nextpc_sel_e;

    typedef struct packed {
        rv_isa_pkg::alu_op_e alu_op;
        src1_sel_e           src1_sel;
        src2_sel_e           src2_sel;
        nextpc_sel_e         nextpc_sel;
        logic                cmp_unsigned;
        logic                word_op;    // addw
        logic                rf_we;
        logic                illegal;
    } ctrl_t;

    typedef struct packed {
        logic [`XLEN-1:0] pc;
        logic [31:0]      inst;
    } queue_entry_t;

endpackage

`default_nettype wire

/* hw/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

    // major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        BRANCH = 7'b1100011,
        OP     = 7'b0110011,
        OP_32  = 7'b0111011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011
    } opcode_e;

    typedef enum logic [2:0] {
        F3_ADD_SUB = 3'b000,
        F3_SLL     = 3'b001,
        F3_SLT     = 3'b010,
        F3_SLTU    = 3'b011,
        F3_XOR     = 3'b100,
        F3_SRL_SRA = 3'b101,
        F3_OR      = 3'b110,
        F3_AND     = 3'b111
    } op_funct3_e;

    typedef enum logic [2:0] {
        F3_BEQ  = 3'b000,
        F3_BNE  = 3'b001,
        F3_BLT  = 3'b100,
        F3_BGE  = 3'b101,
        F3_BLTU = 3'b110,
        F3_BGEU = 3'b111
    } br_funct3_e;

    typedef enum logic [6:0] {
        F7_BASE = 7'b0000000,
        F7_ALT  = 7'b0100000   // sub, sra
    } funct7_e;

    typedef enum logic [3:0] {
        ADD, SUB, SLT, SLTU, AND, OR, XOR, SLL, SRL, SRA,
        PASS_B  // lui
    } alu_op_e;

endpackage

`default_nettype wire

/* hw/rv_core_cfg.svh */
`ifndef RV_CORE_CFG_SVH
`define RV_CORE_CFG_SVH

// data path width
`define XLEN 64

// queue depth, also the upstream's starting credit count
`define QUEUE_DEPTH 4

// architectural registers, x0 included
`define NUM_REGS 32

`endif
